//--- flist.f
+incdir+hw
hw/arb_pkg.sv
hw/grant_if.sv
hw/rr_select.sv
hw/ar_arbiter.sv
hw/r_router.sv
hw/arb_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- Makefile
SIM     := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := tb_top
FLIST   := flist.f
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_top.sv
`timescale 1ns/1ns
`include "arb_consts.svh"

module tb_top;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 3000;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;

    logic                      clk;
    logic                      rst;
    logic                      arready;
    logic [`ARB_ID_W-1:0]      arid;
    logic [`ARB_ADDR_W-1:0]    araddr;
    logic [`ARB_LEN_W-1:0]     arlen;
    logic                      arvalid;
    logic [`ARB_ID_W-1:0]      rid;
    logic                      rvalid;
    logic [`ARB_DATA_W-1:0]    rdata;
    logic                      rready;
    logic [`ARB_NUM_PORTS-1:0] active_ports;
    logic [`ARB_UID_W-1:0]     rd_id [`ARB_NUM_PORTS];
    logic [`ARB_ADDR_W-1:0]    rd_addr [`ARB_NUM_PORTS];
    logic [`ARB_LEN_W-1:0]     rd_len [`ARB_NUM_PORTS];
    logic [`ARB_NUM_PORTS-1:0] rd_info_valid;
    logic [`ARB_NUM_PORTS-1:0] rd_info_rdy;
    logic [`ARB_DATA_W-1:0]    rd_data [`ARB_NUM_PORTS];
    logic [`ARB_NUM_PORTS-1:0] rd_data_valid;
    logic [`ARB_NUM_PORTS-1:0] rd_data_rdy;

    int                        error_count;
    int                        check_count;
    int                        grant_count;
    int                        beat_count;
    integer                    seed;
    logic [`ARB_NUM_PORTS-1:0] acc_q;      // Client handshakes seen at last rising edge
    logic                      beat_q;     // Read beat taken at last rising edge

    arb_top DUT (
        .clk           (clk),
        .rst           (rst),
        .arready       (arready),
        .arid          (arid),
        .araddr        (araddr),
        .arlen         (arlen),
        .arvalid       (arvalid),
        .rid           (rid),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rready        (rready),
        .active_ports  (active_ports),
        .rd_id         (rd_id),
        .rd_addr       (rd_addr),
        .rd_len        (rd_len),
        .rd_info_valid (rd_info_valid),
        .rd_info_rdy   (rd_info_rdy),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .rd_data_rdy   (rd_data_rdy)
    );

    tb_checker u_checker (.*);              // Watches every DUT port

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        acc_q  <= rd_info_valid & rd_info_rdy;
        beat_q <= rvalid & rready;
    end

    // True with the given percentage
    function automatic logic chance(input int unsigned pct);
        int unsigned r;
        r = $unsigned($random(seed));
        return (r % 100) < pct;
    endfunction

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // Requests stay up until acknowledged, then a fresh coin toss
    task automatic drive_clients();
        logic [63:0] r;
        for (int i = 0; i < `ARB_NUM_PORTS; i++) begin
            if (!rd_info_valid[i] || acc_q[i]) begin
                rd_info_valid[i] = chance(50);
                if (rd_info_valid[i]) begin
                    r          = rand64();
                    rd_id[i]   = r[`ARB_UID_W-1:0];
                    rd_addr[i] = r[`ARB_ADDR_W+`ARB_UID_W-1:`ARB_UID_W];
                    rd_len[i]  = r[63:56];
                end
            end
        end
        arready = chance(60);
    endtask

    // Memory side holds a beat until rready
    task automatic drive_memory();
        logic [63:0] r;
        if (!rvalid || beat_q) begin
            rvalid = chance(70);
            if (rvalid) begin
                r   = rand64();
                rid = r[`ARB_ID_W-1:0];   // Random tag, any client
                for (int w = 0; w < `ARB_DATA_W / 32; w++) begin
                    rdata[w*32 +: 32] = $random(seed);
                end
            end
        end
        r           = rand64();
        rd_data_rdy = r[`ARB_NUM_PORTS-1:0];
    endtask

    initial begin
        logic [63:0] r;
        seed          = 32'h52fe7320;
        rst           = 1'b1;
        arready       = 1'b0;
        rid           = '0;
        rvalid        = 1'b0;
        rdata         = '0;
        active_ports  = '1;
        rd_info_valid = '0;
        rd_data_rdy   = '0;
        for (int i = 0; i < `ARB_NUM_PORTS; i++) begin
            rd_id[i]   = '0;
            rd_addr[i] = '0;
            rd_len[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            if (c % 32 == 0) begin
                r            = rand64();
                active_ports = r[`ARB_NUM_PORTS-1:0];  // May be empty, pointer parks
            end
            drive_clients();
            drive_memory();
            @(negedge clk);
        end
        $display("Closing report: %0d checks, %0d errors, %0d grants, %0d read beats",
                 check_count, error_count, grant_count, beat_count);
        if (grant_count == 0 || beat_count == 0) begin
            $display("No traffic completed on the address or data channel");
        end
        if (error_count == 0 && grant_count > 0 && beat_count > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/1ns
`include "arb_consts.svh"

module tb_checker import arb_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      arready,
    input  logic [`ARB_ID_W-1:0]      arid,
    input  logic [`ARB_ADDR_W-1:0]    araddr,
    input  logic [`ARB_LEN_W-1:0]     arlen,
    input  logic                      arvalid,
    input  logic [`ARB_ID_W-1:0]      rid,
    input  logic                      rvalid,
    input  logic [`ARB_DATA_W-1:0]    rdata,
    input  logic                      rready,
    input  logic [`ARB_NUM_PORTS-1:0] active_ports,
    input  logic [`ARB_UID_W-1:0]     rd_id [`ARB_NUM_PORTS],
    input  logic [`ARB_ADDR_W-1:0]    rd_addr [`ARB_NUM_PORTS],
    input  logic [`ARB_LEN_W-1:0]     rd_len [`ARB_NUM_PORTS],
    input  logic [`ARB_NUM_PORTS-1:0] rd_info_valid,
    input  logic [`ARB_NUM_PORTS-1:0] rd_info_rdy,
    input  logic [`ARB_DATA_W-1:0]    rd_data [`ARB_NUM_PORTS],
    input  logic [`ARB_NUM_PORTS-1:0] rd_data_valid,
    input  logic [`ARB_NUM_PORTS-1:0] rd_data_rdy,
    output int                        error_count,
    output int                        check_count,
    output int                        grant_count,
    output int                        beat_count
);

    int   errors   = 0;
    int   checks   = 0;
    int   grants   = 0;
    int   beats    = 0;
    logic rst_seen = 1'b0;                  // First reset edge passed
    logic m_busy   = 1'b0;                  // Model FSM, high in CONNECT
    int   m_ptr    = 0;                     // Model priority pointer
    int   m_port   = 0;                     // Port locked for the current grant
    logic stall_q  = 1'b0;                  // arvalid without arready last cycle
    logic [`ARB_ID_W+`ARB_ADDR_W+`ARB_LEN_W-1:0] ar_q = '0;

    assign error_count = errors;
    assign check_count = checks;
    assign grant_count = grants;
    assign beat_count  = beats;

    task automatic check(input logic ok, input string what);
        checks++;
        if (ok !== 1'b1) begin
            errors++;
            $display("[ERROR] %0t: %s", $time, what);
        end
    endtask

    // First pending port from the pointer upward, wrapping
    function automatic int pick_port(input int ptr, input logic [`ARB_NUM_PORTS-1:0] req);
        int p;
        for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
            p = (ptr + k) % `ARB_NUM_PORTS;
            if (req[p]) begin
                return p;
            end
        end
        return ptr;
    endfunction

    // Nearest active port after the pointer, else stay
    function automatic int next_ptr(input int ptr, input logic [`ARB_NUM_PORTS-1:0] act);
        int p;
        for (int k = 1; k < `ARB_NUM_PORTS; k++) begin
            p = (ptr + k) % `ARB_NUM_PORTS;
            if (act[p]) begin
                return p;
            end
        end
        return ptr;
    endfunction

    task automatic check_address();
        logic [`ARB_ID_W-1:0]      exp_id;
        logic [`ARB_NUM_PORTS-1:0] exp_rdy;
        exp_id  = '0;
        exp_rdy = '0;
        if (m_busy) begin
            exp_id           = {port_idx_t'(m_port), rd_id[m_port]};  // Tag over client ID
            exp_rdy[m_port]  = arready;
            check(arvalid === 1'b1, "arvalid low while a grant is pending");
            check(arid === exp_id, $sformatf("arid %h, expected %h", arid, exp_id));
            check(araddr === rd_addr[m_port],
                  $sformatf("araddr %h, expected %h from port %0d", araddr, rd_addr[m_port],
                            m_port));
            check(arlen === rd_len[m_port],
                  $sformatf("arlen %h, expected %h", arlen, rd_len[m_port]));
        end else begin
            check(arvalid === 1'b0, "arvalid high while the FSM should be idle");
            check({arid, araddr, arlen} === '0, "address bus not zero while idle");
        end
        check(rd_info_rdy === exp_rdy,
              $sformatf("rd_info_rdy %b, expected %b", rd_info_rdy, exp_rdy));
        if (stall_q) begin
            check(arvalid === 1'b1, "arvalid dropped under back-pressure");
            check({arid, araddr, arlen} === ar_q, "payload changed under back-pressure");
        end
        stall_q = arvalid && !arready;
        ar_q    = {arid, araddr, arlen};
    endtask

    task automatic check_read();
        int tag;
        tag = int'(rid[`ARB_ID_W-1:`ARB_UID_W]);  // Owner of the beat
        for (int i = 0; i < `ARB_NUM_PORTS; i++) begin
            check(rd_data[i] === rdata, $sformatf("rd_data[%0d] differs from rdata", i));
            check(rd_data_valid[i] === (rvalid && (i == tag)),
                  $sformatf("rd_data_valid %b with rvalid %b, tag %0d",
                            rd_data_valid, rvalid, tag));
        end
        check(rready === rd_data_rdy[tag],
              $sformatf("rready %b, expected %b from port %0d", rready, rd_data_rdy[tag], tag));
        if (rvalid && rready) begin
            beats++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (rst_seen) begin
                check(arvalid === 1'b0, "arvalid high during reset");
                check(rd_info_rdy === '0, "rd_info_rdy not zero during reset");
            end
            rst_seen = 1'b1;
            m_busy   = 1'b0;
            m_ptr    = 0;                   // Pointer back on port 0
            m_port   = 0;
            stall_q  = 1'b0;
        end else begin
            check_address();
            check_read();
            if (m_busy) begin
                if (arready) begin
                    m_busy = 1'b0;          // Accepted, one idle cycle follows
                    m_ptr  = next_ptr(m_ptr, active_ports);
                    grants++;
                end
            end else if (|rd_info_valid) begin
                m_port = pick_port(m_ptr, rd_info_valid);
                m_busy = 1'b1;
            end
        end
    end

endmodule

//--- hw/arb_top.sv
`timescale 1ns/1ns
`include "arb_consts.svh"

module arb_top import arb_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,

    // Memory read address channel
    input  logic                      arready,
    output logic [`ARB_ID_W-1:0]      arid,
    output logic [`ARB_ADDR_W-1:0]    araddr,
    output logic [`ARB_LEN_W-1:0]     arlen,
    output logic                      arvalid,

    // Memory read data channel
    input  logic [`ARB_ID_W-1:0]      rid,
    input  logic                      rvalid,
    input  logic [`ARB_DATA_W-1:0]    rdata,
    output logic                      rready,

    input  logic [`ARB_NUM_PORTS-1:0] active_ports,  // Ports in the rotation

    // Reader clients
    input  logic [`ARB_UID_W-1:0]     rd_id [`ARB_NUM_PORTS],
    input  logic [`ARB_ADDR_W-1:0]    rd_addr [`ARB_NUM_PORTS],
    input  logic [`ARB_LEN_W-1:0]     rd_len [`ARB_NUM_PORTS],    // Beats
    input  logic [`ARB_NUM_PORTS-1:0] rd_info_valid,
    output logic [`ARB_NUM_PORTS-1:0] rd_info_rdy,
    output logic [`ARB_DATA_W-1:0]    rd_data [`ARB_NUM_PORTS],
    output logic [`ARB_NUM_PORTS-1:0] rd_data_valid,
    input  logic [`ARB_NUM_PORTS-1:0] rd_data_rdy
);

    ar_req_t rd_req [`ARB_NUM_PORTS];       // Client fields packed per port
    ar_req_t ar;                            // Request toward memory

    grant_if g_if ();

    for (genvar i = 0; i < `ARB_NUM_PORTS; i++) begin : g_port
        assign rd_req[i] = {{`ARB_TAG_W{1'b0}}, rd_id[i], rd_addr[i], rd_len[i]};
        assign rd_data[i] = rdata;          // Data bus shared by all clients
    end

    assign arid   = ar.id;
    assign araddr = ar.addr;
    assign arlen  = ar.len;

    rr_select u_rr_select (
        .clk (clk),
        .rst (rst),
        .g   (g_if.selector)
    );

    ar_arbiter u_ar_arbiter (
        .clk          (clk),
        .rst          (rst),
        .rd_valid     (rd_info_valid),
        .rd_req       (rd_req),
        .active_ports (active_ports),
        .arready      (arready),
        .ar           (ar),
        .arvalid      (arvalid),
        .rd_info_rdy  (rd_info_rdy),
        .g            (g_if.arbiter)
    );

    // Data path has no state, fully independent of the address side
    r_router u_r_router (
        .rid           (rid),
        .rvalid        (rvalid),
        .rready        (rready),
        .rd_data_rdy   (rd_data_rdy),
        .rd_data_valid (rd_data_valid)
    );

endmodule

//--- hw/r_router.sv
`timescale 1ns/1ns
`include "arb_consts.svh"

module r_router import arb_pkg::*; (
    input  logic [`ARB_ID_W-1:0]      rid,
    input  logic                      rvalid,
    output logic                      rready,
    input  logic [`ARB_NUM_PORTS-1:0] rd_data_rdy,
    output logic [`ARB_NUM_PORTS-1:0] rd_data_valid
);

    port_idx_t tag;                         // Owner of the returning beat

    assign tag = rid[`ARB_ID_W-1 -: `ARB_TAG_W];

    // Valid only to the tagged client
    always_comb begin
        for (int i = 0; i < `ARB_NUM_PORTS; i++) begin
            rd_data_valid[i] = rvalid && (tag == port_idx_t'(i));
        end
    end

    assign rready = rd_data_rdy[tag];       // Back-pressure from owner only

    // At most one client may see a beat
    always_comb begin
        a_valid_onehot0 : assert ($onehot0(rd_data_valid))
            else $error("r_router: beat steered to several clients (%b)", rd_data_valid);
    end

endmodule

//--- hw/ar_arbiter.sv
`timescale 1ns/1ns
`include "arb_consts.svh"

module ar_arbiter import arb_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ARB_NUM_PORTS-1:0] rd_valid,      // Client request valid
    input  ar_req_t                   rd_req [`ARB_NUM_PORTS],  // Top ID bits zero
    input  logic [`ARB_NUM_PORTS-1:0] active_ports,
    input  logic                      arready,
    output ar_req_t                   ar,
    output logic                      arvalid,
    output logic [`ARB_NUM_PORTS-1:0] rd_info_rdy,   // Acknowledge to clients
    grant_if.arbiter                  g
);

    typedef enum logic {
        IDLE,
        CONNECT
    } state_t;

    state_t    state;
    state_t    state_next;
    port_idx_t cur_port;                    // Grant locked for the whole CONNECT
    logic      accept;                      // Address handshake this cycle

    assign g.req     = rd_valid;
    assign g.active  = active_ports;
    assign accept    = (state == CONNECT) && arready;
    assign g.advance = accept;              // Rotate only on acceptance

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            cur_port <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE && g.any_req) begin
                cur_port <= g.gnt;          // Hold choice while memory stalls
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (g.any_req) begin
                    state_next = CONNECT;
                end
            end
            CONNECT: begin
                if (arready) begin
                    state_next = IDLE;      // One idle cycle between grants
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Request mux, tag insert and acknowledge steering
    always_comb begin
        ar          = '0;                   // Bus quiet while idle
        arvalid     = 1'b0;
        rd_info_rdy = '0;
        if (state == CONNECT) begin
            ar         = rd_req[cur_port];
            ar.id[`ARB_ID_W-1 -: `ARB_TAG_W] = cur_port;  // Port number rides in the ID
            arvalid    = 1'b1;
            rd_info_rdy[cur_port] = arready;
        end
    end

    // Stalled request must stay on the bus unchanged
    a_ar_hold : assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar_arbiter: request changed under back-pressure");

endmodule

//--- hw/rr_select.sv
`timescale 1ns/1ns
`include "arb_consts.svh"

module rr_select import arb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    grant_if.selector g
);

    logic [`ARB_NUM_PORTS-1:0] ptr;         // One-hot priority pointer
    logic [`ARB_NUM_PORTS-1:0] ptr_next;    // Pointer after rotation
    port_idx_t                 ptr_idx;     // Pointer as a port number

    // One-hot to index
    always_comb begin
        ptr_idx = '0;
        for (int i = 0; i < `ARB_NUM_PORTS; i++) begin
            if (ptr[i]) begin
                ptr_idx = port_idx_t'(i);
            end
        end
    end

    // First pending port at or above the pointer, wrapping around
    always_comb begin
        port_idx_t cand;
        logic      found;
        g.gnt = ptr_idx;                    // Nobody waiting, park on pointer
        found = 1'b0;
        for (int k = 0; k < `ARB_NUM_PORTS; k++) begin
            cand = ptr_idx + port_idx_t'(k);  // 2-bit add wraps by itself
            if (!found && g.req[cand]) begin
                g.gnt = cand;
                found = 1'b1;
            end
        end
    end

    assign g.any_req = |g.req;

    // Nearest active port after the pointer; scanned far to near so near wins
    always_comb begin
        logic [`ARB_NUM_PORTS-1:0] cand;
        ptr_next = ptr;                     // No active port ahead, stay
        for (int k = `ARB_NUM_PORTS - 1; k >= 1; k--) begin
            cand = (ptr << k) | (ptr >> (`ARB_NUM_PORTS - k));  // Rotate left by k
            if (|(cand & g.active)) begin
                ptr_next = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= {{(`ARB_NUM_PORTS-1){1'b0}}, 1'b1};  // Port 0 first
        end else if (g.advance) begin
            ptr <= ptr_next;
        end
    end

    // Rotation must never lose or duplicate the pointer bit
    a_ptr_onehot : assert property (@(posedge clk) disable iff (rst) $onehot(ptr))
        else $error("rr_select: priority pointer not one-hot (%b)", ptr);

endmodule

//--- hw/grant_if.sv
`timescale 1ns/1ns
`include "arb_consts.svh"

// Link between the address FSM and the round-robin selector
interface grant_if import arb_pkg::*; ();

    logic [`ARB_NUM_PORTS-1:0] req;         // Pending client requests
    logic [`ARB_NUM_PORTS-1:0] active;      // Ports taking part in rotation
    port_idx_t                 gnt;         // Selected port
    logic                      advance;     // Request accepted, rotate pointer
    logic                      any_req;     // Some client is waiting

    modport arbiter (
        output req,
        output active,
        output advance,
        input  gnt,
        input  any_req
    );

    modport selector (
        input  req,
        input  active,
        input  advance,
        output gnt,
        output any_req
    );

endinterface

//--- hw/arb_pkg.sv
`include "arb_consts.svh"

package arb_pkg;

    // Port number, also the tag in the top ID bits
    typedef logic [`ARB_TAG_W-1:0] port_idx_t;

    // One read-address request, id is the full memory-side width
    typedef struct packed {
        logic [`ARB_ID_W-1:0]   id;     // Tag in top bits on the memory side
        logic [`ARB_ADDR_W-1:0] addr;   // Burst start address
        logic [`ARB_LEN_W-1:0]  len;    // Beats in burst
    } ar_req_t;

endpackage

//--- hw/arb_consts.svh
`ifndef ARB_CONSTS_SVH
`define ARB_CONSTS_SVH

// Client count, fixed by the two-bit port tag in the ID
`define ARB_NUM_PORTS 4

// Memory-side ID, top bits carry the port number
`define ARB_ID_W      8
`define ARB_TAG_W     2
`define ARB_UID_W     (`ARB_ID_W - `ARB_TAG_W)  // Client-side ID

// Read request payload
`define ARB_ADDR_W    33                        // Burst address
`define ARB_LEN_W     8                         // Burst length in beats

// Read data beat
`define ARB_DATA_W    256

`endif
